/* hdl/bus_pkg.sv */
// instruction memory bus types: byte address and instruction word
package bus_pkg;

    //////////////////////////////////////////////////////////////////////
    // bus widths
    //////////////////////////////////////////////////////////////////////

    // byte address on the instruction bus
    localparam int unsigned ADDR_WIDTH = 32;
    // one instruction word, no compressed encodings
    localparam int unsigned DATA_WIDTH = 32;

    // address of a fetch request or of a buffered word
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    // instruction word as returned by the memory
    typedef logic [DATA_WIDTH-1:0] data_t;

endpackage

/* hdl/prefetch_pkg.sv */
// prefetch control types: fetch state encoding, request count and default sizes
package prefetch_pkg;

    //////////////////////////////////////////////////////////////////////
    // fetch FSM encoding
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        IDLE  = 2'd0, // out of reset, waiting for the first branch
        REQ   = 2'd1, // request line high
        STALL = 2'd2  // no room for another request
    } fetch_state_e;

    // in-flight and stale request count, caps MAX_OUTSTANDING at 15
    localparam int unsigned TXN_CNT_WIDTH = 4;
    typedef logic [TXN_CNT_WIDTH-1:0] txn_cnt_t;

    // sizes used when the top level is not overridden
    localparam int unsigned DEFAULT_FIFO_DEPTH      = 4;
    localparam int unsigned DEFAULT_MAX_OUTSTANDING = 2;

endpackage

/* hdl/txn_if.sv */
// request bookkeeping link between the fetch FSM and the transaction tracker
`timescale 1ns/1ns

interface txn_if;
    import prefetch_pkg::*;

    // request and grant seen in the same cycle
    logic     issue;
    // one response returned by the memory, kept or not
    logic     retire;
    // branch, every request in flight turns stale
    logic     flush;
    // requests granted but not yet answered
    txn_cnt_t outstanding;
    // current response belongs to an abandoned stream
    logic     discard;

    // fetch side places requests and reads the bookkeeping
    modport fsm_mp (output issue, output flush, input outstanding, input discard);

    // tracker side counts and flags stale responses
    modport trk_mp (input issue, input retire, input flush, output outstanding, output discard);

endinterface

/* hdl/instr_fifo.sv */
// circular FIFO of instruction word and address pairs with flush and fall-through
`timescale 1ns/1ns

module instr_fifo #(
    parameter int unsigned FIFO_DEPTH   = prefetch_pkg::DEFAULT_FIFO_DEPTH,
    parameter bit          FALL_THROUGH = 1'b0
) (
    input  logic                                          clk_i,
    input  logic                                          rst_ni,
    input  logic                                          flush_i,
    input  logic                                          push_i,
    input  bus_pkg::data_t                                data_i,
    input  bus_pkg::addr_t                                addr_i,
    input  logic                                          pop_i,
    output logic                                          full_o,
    output logic                                          empty_o,
    output logic [((FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1):0] cnt_o,
    output bus_pkg::data_t                                data_o,
    output bus_pkg::addr_t                                addr_o
);
    import bus_pkg::*;

    localparam int unsigned      PTR_W    = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam logic [PTR_W:0]   FULL_CNT = FIFO_DEPTH[PTR_W:0];
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);

    // read and write positions, count is one bit wider to tell full from empty
    logic [PTR_W-1:0] rd_ptr_q, rd_ptr_n;
    logic [PTR_W-1:0] wr_ptr_q, wr_ptr_n;
    logic [PTR_W:0]   cnt_q, cnt_n;

    // storage, word and its address side by side
    data_t data_mem [FIFO_DEPTH];
    addr_t addr_mem [FIFO_DEPTH];

    logic do_push;
    logic do_pop;
    logic bypass;

    //////////////////////////////////////////////////////////////////////
    // status and read side
    //////////////////////////////////////////////////////////////////////

    assign full_o  = (cnt_q == FULL_CNT);
    // an incoming word counts as present when falling through
    assign empty_o = (cnt_q == '0) & ~(FALL_THROUGH & push_i);
    assign cnt_o   = cnt_q;

    // empty FIFO hands the incoming pair straight to the output
    assign bypass  = FALL_THROUGH && (cnt_q == '0) && push_i;

    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    assign data_o  = bypass ? data_i : data_mem[rd_ptr_q];
    assign addr_o  = bypass ? addr_i : addr_mem[rd_ptr_q];

    //////////////////////////////////////////////////////////////////////
    // pointer and count update
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        rd_ptr_n = rd_ptr_q;
        wr_ptr_n = wr_ptr_q;
        cnt_n    = cnt_q;

        // wrap at the last slot, depth need not be a power of two
        if (do_push) begin
            wr_ptr_n = (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
        end
        if (do_pop) begin
            rd_ptr_n = (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
        end

        // simultaneous push and pop leave the count alone
        unique case ({do_push, do_pop})
            2'b10:   cnt_n = cnt_q + 1'b1;
            2'b01:   cnt_n = cnt_q - 1'b1;
            default: cnt_n = cnt_q;
        endcase

        // word consumed in the cycle it arrived, nothing is stored
        if (bypass && pop_i) begin
            rd_ptr_n = rd_ptr_q;
            wr_ptr_n = wr_ptr_q;
            cnt_n    = cnt_q;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_i) begin
            // branch drops everything, a push in this cycle too
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_n;
            wr_ptr_q <= wr_ptr_n;
            cnt_q    <= cnt_n;
        end
    end

    // slot contents only matter once the count covers them
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            data_mem[wr_ptr_q] <= data_i;
            addr_mem[wr_ptr_q] <= addr_i;
        end
    end

endmodule

/* hdl/txn_tracker.sv */
// in-flight request counter and stale response discard counter
`timescale 1ns/1ns

module txn_tracker (
    input logic    clk_i,
    input logic    rst_ni,
    txn_if.trk_mp  txn
);
    import prefetch_pkg::*;

    // granted requests whose response has not come back
    txn_cnt_t outstanding_q, outstanding_n;
    // responses still to be dropped after a branch
    txn_cnt_t discard_q, discard_n;

    //////////////////////////////////////////////////////////////////////
    // count update
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // grant adds one, any response removes one
        outstanding_n = outstanding_q + txn_cnt_t'(txn.issue) - txn_cnt_t'(txn.retire);
        discard_n     = discard_q;

        if (txn.flush) begin
            // all requests left after this cycle belong to the old stream
            discard_n = outstanding_n;
        end else if (txn.retire && (discard_q != '0)) begin
            // stale word returned and dropped
            discard_n = discard_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            outstanding_q <= '0;
            discard_q     <= '0;
        end else begin
            outstanding_q <= outstanding_n;
            discard_q     <= discard_n;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////////////////////////

    assign txn.outstanding = outstanding_q;
    // responses come back in order so the stale ones arrive first
    assign txn.discard     = (discard_q != '0);

endmodule

/* hdl/fetch_fsm.sv */
// fetch FSM with fetch address register, room check and granted-address queue
`timescale 1ns/1ns

module fetch_fsm #(
    parameter int unsigned FIFO_DEPTH      = prefetch_pkg::DEFAULT_FIFO_DEPTH,
    parameter int unsigned MAX_OUTSTANDING = prefetch_pkg::DEFAULT_MAX_OUTSTANDING
) (
    input  logic                                          clk_i,
    input  logic                                          rst_ni,
    input  logic                                          branch_i,
    input  bus_pkg::addr_t                                branch_addr_i,
    input  logic                                          mem_gnt_i,
    input  logic                                          mem_rvalid_i,
    input  logic [((FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1):0] fifo_cnt_i,
    txn_if.fsm_mp                                         txn,
    output logic                                          mem_req_o,
    output bus_pkg::addr_t                                mem_addr_o,
    output bus_pkg::addr_t                                rsp_addr_o
);
    import prefetch_pkg::*;
    import bus_pkg::*;

    localparam int unsigned QPTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;

    fetch_state_e state_q, state_n;
    addr_t        fetch_addr_q;

    logic        grant;
    int unsigned out_cnt;
    int unsigned fifo_cnt;
    logic        room_now;
    logic        room_after_grant;
    logic        room_after_branch;

    // addresses of granted requests, oldest at the read pointer
    addr_t             rsp_q [MAX_OUTSTANDING];
    logic [QPTR_W-1:0] rsp_wr_q;
    logic [QPTR_W-1:0] rsp_rd_q;
    logic              rsp_pop;

    function automatic logic [QPTR_W-1:0] qptr_inc(input logic [QPTR_W-1:0] ptr);
        logic [QPTR_W-1:0] nxt;
        if (ptr == QPTR_W'(MAX_OUTSTANDING - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign mem_req_o  = (state_q == REQ);
    assign mem_addr_o = fetch_addr_q;
    assign grant      = mem_req_o & mem_gnt_i;

    assign txn.issue  = grant;
    assign txn.flush  = branch_i;

    //////////////////////////////////////////////////////////////////////
    // room check
    //////////////////////////////////////////////////////////////////////

    // every in-flight request reserves a FIFO slot, stale ones too
    assign out_cnt  = txn.outstanding;
    assign fifo_cnt = fifo_cnt_i;

    assign room_now          = (fifo_cnt + out_cnt < FIFO_DEPTH) &&
                               (out_cnt < MAX_OUTSTANDING);
    // the grant of this cycle already takes one slot
    assign room_after_grant  = (fifo_cnt + out_cnt + 1 < FIFO_DEPTH) &&
                               (out_cnt + 1 < MAX_OUTSTANDING);
    // FIFO is flushed by the branch, only the requests in flight remain
    assign room_after_branch = (out_cnt + grant < FIFO_DEPTH) &&
                               (out_cnt + grant < MAX_OUTSTANDING);

    //////////////////////////////////////////////////////////////////////
    // state machine and fetch address
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_n = state_q;
        if (branch_i) begin
            // restart at the target, wait first if old requests fill the budget
            state_n = room_after_branch ? REQ : STALL;
        end else begin
            unique case (state_q)
                IDLE:    state_n = IDLE;
                REQ:     if (grant && !room_after_grant) state_n = STALL;
                STALL:   if (room_now) state_n = REQ;
                default: state_n = IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= IDLE;
            fetch_addr_q <= '0;
        end else begin
            state_q <= state_n;
            if (branch_i) begin
                // word aligned, low bits of the target are ignored
                fetch_addr_q <= branch_addr_i & ~addr_t'(3);
            end else if (grant) begin
                fetch_addr_q <= fetch_addr_q + addr_t'(4);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // response address queue
    //////////////////////////////////////////////////////////////////////

    // stale responses had their entries cleared by the branch
    assign rsp_pop = mem_rvalid_i & ~txn.discard;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_wr_q <= '0;
            rsp_rd_q <= '0;
        end else if (branch_i) begin
            rsp_wr_q <= '0;
            rsp_rd_q <= '0;
        end else begin
            if (grant) begin
                rsp_wr_q <= qptr_inc(rsp_wr_q);
            end
            if (rsp_pop) begin
                rsp_rd_q <= qptr_inc(rsp_rd_q);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (grant) begin
            rsp_q[rsp_wr_q] <= fetch_addr_q;
        end
    end

    // response is at least a cycle behind its grant, so the entry is ready
    assign rsp_addr_o = rsp_q[rsp_rd_q];

endmodule

/* hdl/prefetch_buffer.sv */
// instruction prefetch buffer top: fetch FSM, transaction tracker and instruction FIFO
`timescale 1ns/1ns

module prefetch_buffer #(
    parameter int unsigned FIFO_DEPTH      = prefetch_pkg::DEFAULT_FIFO_DEPTH,
    parameter int unsigned MAX_OUTSTANDING = prefetch_pkg::DEFAULT_MAX_OUTSTANDING,
    parameter bit          FALL_THROUGH    = 1'b0
) (
    input  logic           clk_i,
    input  logic           rst_ni,
    // branch side
    input  logic           branch_i,
    input  bus_pkg::addr_t branch_addr_i,
    // instruction memory side
    output logic           mem_req_o,
    output bus_pkg::addr_t mem_addr_o,
    input  logic           mem_gnt_i,
    input  logic           mem_rvalid_i,
    input  bus_pkg::data_t mem_rdata_i,
    // core side
    output logic           instr_valid_o,
    output bus_pkg::data_t instr_o,
    output bus_pkg::addr_t instr_addr_o,
    input  logic           instr_ready_i
);
    import bus_pkg::*;

    localparam int unsigned CNT_W = ((FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1) + 1;

    logic [CNT_W-1:0] fifo_cnt;
    logic             fifo_full;
    logic             fifo_empty;
    logic             fifo_push;
    logic             fifo_pop;
    addr_t            rsp_addr;

    txn_if txn ();

    //////////////////////////////////////////////////////////////////////
    // glue
    //////////////////////////////////////////////////////////////////////

    // every response retires a request, stale or not
    assign txn.retire    = mem_rvalid_i;
    // only responses of the current stream enter the FIFO
    assign fifo_push     = mem_rvalid_i & ~txn.discard;
    assign fifo_pop      = instr_valid_o & instr_ready_i;
    assign instr_valid_o = ~fifo_empty;

    fetch_fsm #(
        .FIFO_DEPTH      (FIFO_DEPTH),
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) fetch_fsm0 (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .branch_i      (branch_i),
        .branch_addr_i (branch_addr_i),
        .mem_gnt_i     (mem_gnt_i),
        .mem_rvalid_i  (mem_rvalid_i),
        .fifo_cnt_i    (fifo_cnt),
        .txn           (txn.fsm_mp),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .rsp_addr_o    (rsp_addr)
    );

    txn_tracker txn_tracker0 (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .txn    (txn.trk_mp)
    );

    // branch flushes the buffered words of the old stream
    instr_fifo #(
        .FIFO_DEPTH   (FIFO_DEPTH),
        .FALL_THROUGH (FALL_THROUGH)
    ) instr_fifo0 (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (branch_i),
        .push_i  (fifo_push),
        .data_i  (mem_rdata_i),
        .addr_i  (rsp_addr),
        .pop_i   (fifo_pop),
        .full_o  (fifo_full),
        .empty_o (fifo_empty),
        .cnt_o   (fifo_cnt),
        .data_o  (instr_o),
        .addr_o  (instr_addr_o)
    );

endmodule

/* verification/prefetch_sva.sv */
// protocol checker for the prefetch buffer and its bind into the top level
`timescale 1ns/1ns

module prefetch_sva #(
    parameter int unsigned MAX_OUTSTANDING = prefetch_pkg::DEFAULT_MAX_OUTSTANDING,
    parameter bit          FALL_THROUGH    = 1'b0
) (
    input logic                    clk_i,
    input logic                    rst_ni,
    input logic                    branch_i,
    input logic                    mem_req_i,
    input logic                    mem_gnt_i,
    input bus_pkg::addr_t          mem_addr_i,
    input logic                    fifo_push_i,
    input logic                    fifo_full_i,
    input logic                    fifo_pop_i,
    input logic                    fifo_cnt_zero_i,
    input prefetch_pkg::txn_cnt_t  outstanding_i
);

    //////////////////////////////////////////////////////////////////////
    // FIFO side
    //////////////////////////////////////////////////////////////////////

    // room rule keeps responses away from a full FIFO
    push_not_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fifo_push_i |-> !fifo_full_i)
        else $error("push into a full instruction FIFO");

    // a take needs a stored word, or one falling through this cycle
    pop_not_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fifo_pop_i |-> (!fifo_cnt_zero_i || (FALL_THROUGH && fifo_push_i)))
        else $error("pop from an empty instruction FIFO");

    //////////////////////////////////////////////////////////////////////
    // memory side
    //////////////////////////////////////////////////////////////////////

    // an ungranted request holds its address unless a branch moves it
    addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req_i && !mem_gnt_i && !branch_i) |=> $stable(mem_addr_i))
        else $error("request address changed while waiting for a grant");

    outstanding_cap: assert property (@(posedge clk_i) disable iff (!rst_ni)
        outstanding_i <= MAX_OUTSTANDING)
        else $error("too many requests in flight");

endmodule

bind prefetch_buffer prefetch_sva #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING),
    .FALL_THROUGH    (FALL_THROUGH)
) sva0 (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .branch_i        (branch_i),
    .mem_req_i       (mem_req_o),
    .mem_gnt_i       (mem_gnt_i),
    .mem_addr_i      (mem_addr_o),
    .fifo_push_i     (fifo_push),
    .fifo_full_i     (fifo_full),
    .fifo_pop_i      (fifo_pop),
    .fifo_cnt_zero_i (fifo_cnt == '0),
    .outstanding_i   (txn.outstanding)
);

/* verification/prefetch_tb.sv */
// testbench: clock, reset, memory model, core consumer, reference function, checks, report
`timescale 1ns/1ns

module prefetch_tb;
    import bus_pkg::*;

    localparam int FIFO_DEPTH     = prefetch_pkg::DEFAULT_FIFO_DEPTH;
    localparam int TIMEOUT_CYCLES = 5000;

    logic  clk_i;
    logic  rst_ni;
    logic  branch_i;
    addr_t branch_addr_i;
    logic  mem_req_o;
    addr_t mem_addr_o;
    logic  mem_gnt_i;
    logic  mem_rvalid_i;
    data_t mem_rdata_i;
    logic  instr_valid_o;
    data_t instr_o;
    addr_t instr_addr_o;
    logic  instr_ready_i;

    logic [31:0] rng = 32'd95067;
    int          cyc = 0;
    // granted addresses and the cycle each response is due
    addr_t       rsp_addr_q[$];
    int          rsp_due_q[$];
    logic        ready_en = 1'b0;
    addr_t       exp_addr = '0;
    int          take_cnt = 0;
    int          live_grants = 0;
    int          live_takes = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_ok = 0;
    string       cur_test = "reset";

    prefetch_buffer dut0 (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // instruction memory contents, a fixed hash of the word address
    function automatic data_t mem_word(input addr_t a);
        return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5ac3c3;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp, act);
        $display("FAIL %s: %s expected %h actual %h", cur_test, what, exp, act);
        errors++;
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_errors = errors;
    endtask

    task automatic close_test();
        tests_run++;
        if (errors == test_errors) begin
            tests_ok++;
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d errors", cur_test, errors - test_errors);
        end
    endtask

    // one-cycle branch pulse, driven just after the edge
    task automatic do_branch(input addr_t target);
        @(posedge clk_i);
        #5;
        branch_i = 1'b1;
        branch_addr_i = target;
        @(posedge clk_i);
        #5;
        branch_i = 1'b0;
    endtask

    task automatic wait_takes(input int n);
        int target;
        target = take_cnt + n;
        while (take_cnt < target) begin
            @(posedge clk_i);
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // memory model and core consumer
    //////////////////////////////////////////////////////////////////////

    initial begin
        mem_gnt_i = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i = '0;
        instr_ready_i = 1'b0;
        forever begin
            @(posedge clk_i);
            #5;
            rng = lcg_next(rng);
            mem_gnt_i = rng[20];
            rng = lcg_next(rng);
            // ready about three cycles in four while enabled
            instr_ready_i = ready_en && (rng[21:20] != 2'b00);
            // in order, at most one response per cycle
            if (rsp_addr_q.size() > 0 && rsp_due_q[0] <= cyc) begin
                mem_rvalid_i = 1'b1;
                mem_rdata_i = mem_word(rsp_addr_q.pop_front());
                void'(rsp_due_q.pop_front());
            end else begin
                mem_rvalid_i = 1'b0;
                mem_rdata_i = '0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // compare process, samples in the middle of the cycle
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (mem_req_o && mem_gnt_i) begin
                rng = lcg_next(rng);
                rsp_addr_q.push_back(mem_addr_o);
                // latency of 1 to 3 cycles after the grant
                rsp_due_q.push_back(cyc + 1 + int'(rng[18:16] % 3'd3));
                live_grants++;
            end
            // a take in the branch cycle still belongs to the old stream
            if (instr_valid_o && instr_ready_i) begin
                if (instr_addr_o !== exp_addr) begin
                    report_mismatch("instr_addr_o", exp_addr, instr_addr_o);
                end
                if (instr_o !== mem_word(exp_addr)) begin
                    report_mismatch("instr_o", mem_word(exp_addr), instr_o);
                end
                exp_addr += 4;
                live_takes++;
                take_cnt++;
            end
            if (branch_i) begin
                exp_addr = branch_addr_i;
                live_grants = 0;
                live_takes = 0;
            end
            if (live_grants - live_takes > FIFO_DEPTH) begin
                $display("FAIL %s: words ahead of the core expected <= %0d actual %0d",
                         cur_test, FIFO_DEPTH, live_grants - live_takes);
                errors++;
            end
        end
    end

    initial begin
        while (cyc < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
        end
        $display("timeout: run stopped after %0d cycles", cyc);
        $display("tests failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst_ni = 1'b0;
        branch_i = 1'b0;
        branch_addr_i = '0;
        repeat (4) @(posedge clk_i);
        #5;
        rst_ni = 1'b1;

        begin_test("reset_idle");
        repeat (10) begin
            @(negedge clk_i);
            if (mem_req_o !== 1'b0) begin
                report_mismatch("mem_req_o", 32'd0, 32'(mem_req_o));
            end
            if (instr_valid_o !== 1'b0) begin
                report_mismatch("instr_valid_o", 32'd0, 32'(instr_valid_o));
            end
        end
        close_test();

        begin_test("seq_stream");
        @(posedge clk_i);
        ready_en = 1'b1;
        do_branch(32'h0000_1000);
        wait_takes(40);
        close_test();

        begin_test("back_pressure");
        @(posedge clk_i);
        ready_en = 1'b0;
        repeat (50) @(posedge clk_i);
        @(negedge clk_i);
        // buffer should hold words by now
        if (instr_valid_o !== 1'b1) begin
            report_mismatch("instr_valid_o", 32'd1, 32'(instr_valid_o));
        end
        ready_en = 1'b1;
        wait_takes(20);
        close_test();

        begin_test("branch_in_flight");
        // wait for a response due after the coming branch cycle
        do begin
            @(negedge clk_i);
        end while (rsp_due_q.size() == 0 || rsp_due_q[rsp_due_q.size() - 1] <= cyc + 1);
        do_branch(32'h0000_2400);
        wait_takes(20);
        close_test();

        begin_test("double_branch");
        @(posedge clk_i);
        #5;
        branch_i = 1'b1;
        branch_addr_i = 32'h0000_3000;
        @(posedge clk_i);
        #5;
        branch_addr_i = 32'h0000_4800;
        @(posedge clk_i);
        #5;
        branch_i = 1'b0;
        wait_takes(20);
        close_test();

        $display("summary: %0d run, %0d ok, %0d check errors", tests_run, tests_ok, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* build.f */
hdl/bus_pkg.sv
hdl/prefetch_pkg.sv
hdl/txn_if.sv
hdl/instr_fifo.sv
hdl/txn_tracker.sv
hdl/fetch_fsm.sv
hdl/prefetch_buffer.sv
verification/prefetch_sva.sv
verification/prefetch_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the prefetch buffer testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module prefetch_tb -o prefetch_sim
./obj_dir/prefetch_sim | tee sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished"
